/* verilog.f */
src/sketch_pkg.sv
src/flow_parser.sv
src/flow_hash.sv
src/record_queue.sv
src/sketch_top.sv
verif/sketch_props.sv
verif/sketch_checker.sv
verif/tb_sketch.sv

/* verif/tb_sketch.sv */
// testbench top with clock, reset, random packet stimulus, reference hashing and report
`timescale 1ns/1ps
`default_nettype none

module tb_sketch
    import sketch_pkg::*;
();

    localparam int DATA_W     = 128;        // dut defaults
    localparam int ADDR_W     = 10;
    localparam int KEEP_W     = DATA_W / 8;
    localparam int WAIT_LIMIT = 400;        // cycles per wait

    logic               clk;
    logic               memreset;
    logic               s_valid;
    logic [DATA_W-1:0]  s_data;
    logic [KEEP_W-1:0]  s_keep;
    logic               s_last;
    logic               s_ready;
    logic               mem_wr_valid;
    logic [ADDR_W-1:0]  mem_wr_addr;
    logic [35:0]        mem_wr_data;
    logic               mem_wr_ready;
    bit                 stall_on;           // random write port stalls
    int                 sent;
    int                 timeouts;
    string              test_name;

    sketch_top dut_i (
        .clk(clk), .memreset(memreset),
        .s_valid(s_valid), .s_data(s_data), .s_keep(s_keep), .s_last(s_last),
        .s_ready(s_ready),
        .mem_wr_valid(mem_wr_valid), .mem_wr_addr(mem_wr_addr),
        .mem_wr_data(mem_wr_data), .mem_wr_ready(mem_wr_ready)
    );

    sketch_checker #(.ADDR_W(ADDR_W)) check_i (
        .clk(clk), .memreset(memreset),
        .mem_wr_valid(mem_wr_valid), .mem_wr_ready(mem_wr_ready),
        .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;                  // 40 ns period

    // memory controller side, low about 1 in 3 when stalling
    always @(negedge clk)
    begin
        if (stall_on)
            mem_wr_ready <= ($urandom_range(2) != 0);
        else
            mem_wr_ready <= 1'b1;
    end

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // sum of byte i times (key + 2i), low width bits
    function automatic logic [31:0] keyed_hash(input flow_tuple_t t, input logic [15:0] key,
                                               input int width);
        longint sum;
        sum = 0;
        for (int i = 0; i < TUPLE_BYTES; i++)
            sum = sum + longint'(t[8*i +: 8]) * (longint'(key) + 2 * i);
        return 32'(sum & ((longint'(1) << width) - 1));
    endfunction

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic wait_accept();
        int n;
        n = 0;
        @(posedge clk);
        while (!s_ready && n < WAIT_LIMIT)
        begin
            n++;
            @(posedge clk);
        end
        if (!s_ready)
        begin
            timeouts++;
            $display("timeout: s_ready stayed low for %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic send_packet(input int beats, input int gap);
        flow_tuple_t        tuple;
        logic [DATA_W-1:0]  data;
        logic [KEEP_W-1:0]  keep;
        logic [COUNT_W-1:0] count;
        count = '0;
        for (int b = 0; b < beats; b++)
        begin
            data = {$urandom(), $urandom(), $urandom(), $urandom()};
            keep = '1;
            if (b == beats - 1)
            begin
                keep = KEEP_W'($urandom());     // partial last beat, never empty
                if (keep == '0)
                    keep = 1;
            end
            if (b == 0)
                tuple = data[TUPLE_BYTES*8-1:0];
            count = count + COUNT_W'($countones(keep));
            @(negedge clk);
            s_valid = 1'b1;
            s_data  = data;
            s_keep  = keep;
            s_last  = (b == beats - 1);
            wait_accept();
        end
        sent++;
        check_i.add_expected(ADDR_W'(keyed_hash(tuple, ADDR_KEY, ADDR_W)),
                             {FLOW_ID_W'(keyed_hash(tuple, ID_KEY, FLOW_ID_W)), count},
                             test_name);
        if (gap > 0)
        begin
            @(negedge clk);
            s_valid = 1'b0;
            s_last  = 1'b0;
            repeat (gap - 1) @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (check_i.write_count < sent && n < WAIT_LIMIT)
        begin
            n++;
            @(posedge clk);
        end
        if (check_i.write_count < sent)
        begin
            timeouts++;
            $display("timeout: only %0d of %0d records reached the write port",
                     check_i.write_count, sent);
        end
    endtask

    task automatic run_phase(input string name, input int packets, input int max_beats,
                             input int max_gap, input bit stall);
        test_name = name;
        stall_on  = stall;
        for (int p = 0; p < packets && timeouts == 0; p++)
            send_packet($urandom_range(max_beats, 1), $urandom_range(max_gap, 0));
        @(negedge clk);
        s_valid = 1'b0;         // no repeat of the last beat
        s_last  = 1'b0;
        wait_drain();
    endtask

    initial
    begin
        int errors;
        void'($urandom(80335));
        memreset     = 1'b1;
        s_valid      = 1'b0;
        s_data       = '0;
        s_keep       = '0;
        s_last       = 1'b0;
        mem_wr_ready = 1'b1;
        stall_on     = 1'b0;
        sent         = 0;
        timeouts     = 0;
        test_name    = "reset";
        repeat (4) @(posedge clk);
        @(negedge clk);
        memreset = 1'b0;
        repeat (6) @(negedge clk);          // idle, any write here is stray

        run_phase("single_beat", 8, 1, 3, 1'b0);
        run_phase("multi_beat", 24, 4, 3, 1'b0);
        run_phase("random_stall", 40, 4, 2, 1'b1);
        run_phase("back_to_back", 30, 1, 0, 1'b0);
        run_phase("back_to_back_stall", 30, 2, 0, 1'b1);
        repeat (10) @(negedge clk);         // catch late duplicates

        errors = check_i.error_count + dut_i.queue_i.props_i.fail_count + timeouts;
        if (check_i.write_count != sent)
        begin
            errors++;
            $display("write count %0d does not match %0d packets sent",
                     check_i.write_count, sent);
        end
        $display("%0d packets, %0d writes, %0d mismatches, %0d assertion fails, %0d timeouts",
                 sent, check_i.write_count, check_i.error_count,
                 dut_i.queue_i.props_i.fail_count, timeouts);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/sketch_checker.sv */
// write port monitor with the expected record queue and field-wise compare
`timescale 1ns/1ps
`default_nettype none

module sketch_checker
    import sketch_pkg::*;
#(
    parameter int ADDR_W = 10
)
(
    input  wire                     clk,
    input  wire                     memreset,
    input  wire                     mem_wr_valid,
    input  wire                     mem_wr_ready,
    input  wire  [ADDR_W-1:0]       mem_wr_addr,
    input  wire  [35:0]             mem_wr_data
);

    logic [ADDR_W-1:0]  exp_addr_q [$];     // one entry per packet, in send order
    logic [35:0]        exp_data_q [$];
    string              exp_name_q [$];     // phase that sent it
    int                 error_count = 0;
    int                 write_count = 0;

    task automatic add_expected(input logic [ADDR_W-1:0] addr, input logic [35:0] data,
                                input string name);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
        exp_name_q.push_back(name);
    endtask

    //////////////////////////////////////////////////
    // compare on every write transfer
    //////////////////////////////////////////////////

    always @(posedge clk)
    begin : compare
        sram_word_u        exp_w;
        sram_word_u        act_w;
        logic [ADDR_W-1:0] exp_addr;
        string             name;
        if (!memreset && mem_wr_valid)
        begin
            if (exp_addr_q.size() == 0)
            begin
                error_count++;      // stray or duplicated record
                $display("write port valid at %0t with no packet outstanding", $time);
            end
            else if (mem_wr_ready)
            begin
                exp_addr  = exp_addr_q.pop_front();
                exp_w.raw = exp_data_q.pop_front();
                name      = exp_name_q.pop_front();
                act_w.raw = mem_wr_data;        // decode by field
                if (mem_wr_addr !== exp_addr)
                begin
                    error_count++;
                    $display("** Error %s: address expected %h, actual %h",
                             name, exp_addr, mem_wr_addr);
                end
                if (act_w.fields.flow_id !== exp_w.fields.flow_id)
                begin
                    error_count++;
                    $display("** Error %s: flow_id expected %h, actual %h",
                             name, exp_w.fields.flow_id, act_w.fields.flow_id);
                end
                if (act_w.fields.byte_count !== exp_w.fields.byte_count)
                begin
                    error_count++;
                    $display("** Error %s: byte_count expected %0d, actual %0d",
                             name, exp_w.fields.byte_count, act_w.fields.byte_count);
                end
            end
            if (mem_wr_ready)
                write_count++;
        end
    end

endmodule

`default_nettype wire

/* verif/sketch_props.sv */
// handshake and reset assertions for the record queue, bound into every instance
`timescale 1ns/1ps
`default_nettype none

module sketch_props
#(
    parameter int ADDR_W      = 10,
    parameter int QUEUE_DEPTH = 4
)
(
    input  wire                             clk,
    input  wire                             memreset,
    input  wire                             rec_valid,
    input  wire                             rec_ready,
    input  wire                             mem_wr_valid,
    input  wire                             mem_wr_ready,
    input  wire  [ADDR_W-1:0]               mem_wr_addr,
    input  wire  [35:0]                     mem_wr_data
);

    int fail_count = 0;     // read by the testbench at the end
    int held       = 0;     // records held, counted from port handshakes

    always @(posedge clk)
    begin
        if (memreset)
            held <= 0;
        else
            held <= held + int'(rec_valid && rec_ready) - int'(mem_wr_valid && mem_wr_ready);
    end

    // stalled write holds valid, address and word
    a_stall_hold : assert property (@(posedge clk) disable iff (memreset)
        mem_wr_valid && !mem_wr_ready |=>
            mem_wr_valid && $stable(mem_wr_addr) && $stable(mem_wr_data))
    else
    begin
        fail_count++;
        $error("write port changed while stalled");
    end

    // back-pressure only from a full queue
    a_ready_full : assert property (@(posedge clk) disable iff (memreset)
        !rec_ready |-> held == QUEUE_DEPTH)
    else
    begin
        fail_count++;
        $error("rec_ready low with the queue not full");
    end

    a_reset_idle : assert property (@(posedge clk) memreset |=> !mem_wr_valid)
    else
    begin
        fail_count++;
        $error("mem_wr_valid high right after memreset");
    end

endmodule

bind record_queue sketch_props #(.ADDR_W(ADDR_W), .QUEUE_DEPTH(QUEUE_DEPTH)) props_i (
    .clk(clk), .memreset(memreset), .rec_valid(rec_valid), .rec_ready(rec_ready),
    .mem_wr_valid(mem_wr_valid), .mem_wr_ready(mem_wr_ready),
    .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data)
);

`default_nettype wire

/* src/sketch_top.sv */
// flow sketch top level, parser into hash into record queue
`timescale 1ns/1ps
`default_nettype none

module sketch_top
    import sketch_pkg::*;
#(
    parameter int DATA_W      = 128,
    parameter int ADDR_W      = 10,
    parameter int QUEUE_DEPTH = 4
)
(
    input  wire                     clk,
    input  wire                     memreset,

    // packet stream in
    input  wire                     s_valid,
    input  wire  [DATA_W-1:0]       s_data,
    input  wire  [DATA_W/8-1:0]     s_keep,
    input  wire                     s_last,
    output logic                    s_ready,

    // toward the memory controller
    output logic                    mem_wr_valid,
    output logic [ADDR_W-1:0]       mem_wr_addr,
    output logic [35:0]             mem_wr_data,
    input  wire                     mem_wr_ready
);

    // parser -> hash
    logic               desc_valid;
    flow_tuple_t        desc_tuple;
    logic [COUNT_W-1:0] desc_count;
    logic               desc_ready;

    // hash -> queue
    logic                 rec_valid;
    logic [ADDR_W-1:0]    rec_addr;
    logic [FLOW_ID_W-1:0] rec_id;
    logic [COUNT_W-1:0]   rec_count;
    logic                 rec_ready;

    flow_parser #(.DATA_W(DATA_W)) parser_i (
        .clk(clk), .memreset(memreset),
        .s_valid(s_valid), .s_data(s_data), .s_keep(s_keep), .s_last(s_last),
        .s_ready(s_ready),
        .desc_valid(desc_valid), .desc_tuple(desc_tuple), .desc_count(desc_count),
        .desc_ready(desc_ready)
    );

    flow_hash #(.ADDR_W(ADDR_W)) hash_i (
        .clk(clk), .memreset(memreset),
        .desc_valid(desc_valid), .desc_tuple(desc_tuple), .desc_count(desc_count),
        .desc_ready(desc_ready),
        .rec_valid(rec_valid), .rec_addr(rec_addr), .rec_id(rec_id),
        .rec_count(rec_count), .rec_ready(rec_ready)
    );

    record_queue #(.ADDR_W(ADDR_W), .QUEUE_DEPTH(QUEUE_DEPTH)) queue_i (
        .clk(clk), .memreset(memreset),
        .rec_valid(rec_valid), .rec_addr(rec_addr), .rec_id(rec_id),
        .rec_count(rec_count), .rec_ready(rec_ready),
        .mem_wr_valid(mem_wr_valid), .mem_wr_addr(mem_wr_addr),
        .mem_wr_data(mem_wr_data), .mem_wr_ready(mem_wr_ready)
    );

endmodule

`default_nettype wire

/* src/record_queue.sv */
// record packing into the 36 bit sram word and queue toward the write port
`timescale 1ns/1ps
`default_nettype none

module record_queue
    import sketch_pkg::*;
#(
    parameter int ADDR_W      = 10,
    parameter int QUEUE_DEPTH = 4           // power of two
)
(
    input  wire                     clk,
    input  wire                     memreset,

    // record in
    input  wire                     rec_valid,
    input  wire  [ADDR_W-1:0]       rec_addr,
    input  wire  [FLOW_ID_W-1:0]    rec_id,
    input  wire  [COUNT_W-1:0]      rec_count,
    output logic                    rec_ready,

    // sram write port
    output logic                    mem_wr_valid,
    output logic [ADDR_W-1:0]       mem_wr_addr,
    output logic [35:0]             mem_wr_data,
    input  wire                     mem_wr_ready
);

    localparam int             PTR_W      = $clog2(QUEUE_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W+1)'(QUEUE_DEPTH);

    logic [ADDR_W-1:0]  addr_mem [QUEUE_DEPTH];    // entry addresses
    logic [35:0]        data_mem [QUEUE_DEPTH];    // entry words, raw view
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     occupancy;                 // 0 .. QUEUE_DEPTH
    logic               push;
    logic               pop;
    sram_word_u         rec_word;                  // packed record

    // pack by field, store raw
    always_comb
    begin
        rec_word.fields.flow_id    = rec_id;
        rec_word.fields.byte_count = rec_count;
    end

    assign rec_ready    = (occupancy != FULL_COUNT);   // back-pressure only when full
    assign push         = rec_valid && rec_ready;
    assign mem_wr_valid = (occupancy != '0);
    assign pop          = mem_wr_valid && mem_wr_ready;

    // head entry straight onto the port
    assign mem_wr_addr = addr_mem[rd_ptr];
    assign mem_wr_data = data_mem[rd_ptr];

    //////////////////////////////////////////////////
    // storage and pointers
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            addr_mem[wr_ptr] <= rec_addr;
            data_mem[wr_ptr] <= rec_word.raw;
        end
    end

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is 2**n
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            // push and pop together leave occupancy alone
            if (push && !pop)
                occupancy <= occupancy + 1'b1;
            else if (pop && !push)
                occupancy <= occupancy - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/flow_hash.sv */
// two stage pipelined multiplicative hashing for sketch address and flow id
`timescale 1ns/1ps
`default_nettype none

module flow_hash
    import sketch_pkg::*;
#(
    parameter int ADDR_W = 10               // sketch address bits
)
(
    input  wire                     clk,
    input  wire                     memreset,

    // descriptor in
    input  wire                     desc_valid,
    input  wire  flow_tuple_t       desc_tuple,
    input  wire  [COUNT_W-1:0]      desc_count,
    output logic                    desc_ready,

    // record out
    output logic                    rec_valid,
    output logic [ADDR_W-1:0]       rec_addr,
    output logic [FLOW_ID_W-1:0]    rec_id,
    output logic [COUNT_W-1:0]      rec_count,
    input  wire                     rec_ready
);

    localparam int COEF_W = 17;             // key + 2*i never overflows
    localparam int PROD_W = 8 + COEF_W;     // exact byte product
    localparam int SUM_W  = PROD_W + 4;     // room for 13 terms

    // per byte multiplier, key + 2*idx
    function automatic logic [COEF_W-1:0] coef(input logic [15:0] key, input int idx);
        coef = COEF_W'(key) + COEF_W'(2 * idx);
    endfunction

    logic [PROD_W-1:0]  addr_prod    [TUPLE_BYTES];    // comb, from desc
    logic [PROD_W-1:0]  id_prod      [TUPLE_BYTES];
    logic [PROD_W-1:0]  s1_addr_prod [TUPLE_BYTES];    // stage one regs
    logic [PROD_W-1:0]  s1_id_prod   [TUPLE_BYTES];
    logic [COUNT_W-1:0] s1_count;                      // rides along
    logic               s1_valid;
    logic [SUM_W-1:0]   addr_sum;
    logic [SUM_W-1:0]   id_sum;
    logic               s1_en;                         // stage one loads
    logic               s2_en;                         // stage two loads

    // a stage moves when the one after it is empty or moving
    assign s2_en      = !rec_valid || rec_ready;
    assign s1_en      = !s1_valid || s2_en;
    assign desc_ready = s1_en;          // low only with both stages full

    //////////////////////////////////////////////////
    // stage one, keyed byte products
    //////////////////////////////////////////////////

    always_comb
    begin
        for (int i = 0; i < TUPLE_BYTES; i++)
        begin
            addr_prod[i] = PROD_W'(desc_tuple[8*i +: 8]) * PROD_W'(coef(ADDR_KEY, i));
            id_prod[i]   = PROD_W'(desc_tuple[8*i +: 8]) * PROD_W'(coef(ID_KEY, i));
        end
    end

    always_ff @(posedge clk)
    begin
        if (s1_en && desc_valid)
        begin
            s1_addr_prod <= addr_prod;
            s1_id_prod   <= id_prod;
            s1_count     <= desc_count;
        end
    end

    //////////////////////////////////////////////////
    // stage two, sum and truncate
    //////////////////////////////////////////////////

    always_comb
    begin
        addr_sum = '0;
        id_sum   = '0;
        for (int i = 0; i < TUPLE_BYTES; i++)
        begin
            addr_sum = addr_sum + SUM_W'(s1_addr_prod[i]);
            id_sum   = id_sum + SUM_W'(s1_id_prod[i]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (s2_en && s1_valid)
        begin
            rec_addr  <= addr_sum[ADDR_W-1:0];      // low bits only
            rec_id    <= id_sum[FLOW_ID_W-1:0];
            rec_count <= s1_count;
        end
    end

    // valid bits
    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            s1_valid  <= 1'b0;
            rec_valid <= 1'b0;
        end
        else
        begin
            if (s1_en)
                s1_valid <= desc_valid;
            if (s2_en)
                rec_valid <= s1_valid;
        end
    end

endmodule

`default_nettype wire

/* src/flow_parser.sv */
// stream input stage with five-tuple capture and per-packet byte counting
`timescale 1ns/1ps
`default_nettype none

module flow_parser
    import sketch_pkg::*;
#(
    parameter int DATA_W = 128              // stream width, 104 or more
)
(
    input  wire                     clk,
    input  wire                     memreset,

    // packet stream in
    input  wire                     s_valid,
    input  wire  [DATA_W-1:0]       s_data,
    input  wire  [DATA_W/8-1:0]     s_keep,
    input  wire                     s_last,
    output logic                    s_ready,

    // one descriptor per packet
    output logic                    desc_valid,
    output flow_tuple_t             desc_tuple,
    output logic [COUNT_W-1:0]      desc_count,
    input  wire                     desc_ready
);

    localparam int KEEP_W  = DATA_W / 8;
    localparam int TUPLE_W = TUPLE_BYTES * 8;

    logic               first_beat;     // next accepted beat opens a packet
    logic               beat;           // beat accepted this cycle
    flow_tuple_t        beat_tuple;     // low bytes of the current beat
    flow_tuple_t        tuple_hold;     // tuple of the packet in progress
    logic [COUNT_W-1:0] count_acc;      // bytes of earlier beats
    logic [COUNT_W-1:0] keep_ones;      // set keep bits, this beat
    logic [COUNT_W-1:0] count_next;     // running total incl this beat

    // stall input while a descriptor is parked and not taken
    assign s_ready    = !desc_valid || desc_ready;
    assign beat       = s_valid && s_ready;
    assign beat_tuple = s_data[TUPLE_W-1:0];   // no header parsing, tuple up front

    //////////////////////////////////////////////////
    // byte counting
    //////////////////////////////////////////////////

    // popcount of keep
    always_comb
    begin
        keep_ones = '0;
        for (int i = 0; i < KEEP_W; i++)
        begin
            keep_ones = keep_ones + COUNT_W'(s_keep[i]);
        end
    end

    assign count_next = count_acc + keep_ones;     // wraps at COUNT_W

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            first_beat <= 1'b1;
            count_acc  <= '0;
        end
        else if (beat)
        begin
            first_beat <= s_last;                       // rearm after last beat
            count_acc  <= s_last ? '0 : count_next;     // clear for next packet
        end
    end

    // tuple from the first beat only
    always_ff @(posedge clk)
    begin
        if (beat && first_beat)
        begin
            tuple_hold <= beat_tuple;
        end
    end

    //////////////////////////////////////////////////
    // descriptor register
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            desc_valid <= 1'b0;
        end
        else if (beat && s_last)
        begin
            desc_valid <= 1'b1;         // valid the cycle after s_last
        end
        else if (desc_ready)
        begin
            desc_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (beat && s_last)
        begin
            // single beat packet has no held tuple yet
            desc_tuple <= first_beat ? beat_tuple : tuple_hold;
            desc_count <= count_next;
        end
    end

endmodule

`default_nettype wire

/* src/sketch_pkg.sv */
// shared field widths, hash keys, tuple type and the sram record word
`default_nettype none

package sketch_pkg;

    //////////////////////////////////////////////////
    // flow tuple
    //////////////////////////////////////////////////

    // src ip 4, dst ip 4, src port 2, dst port 2, proto 1
    localparam int TUPLE_BYTES = 13;

    typedef logic [TUPLE_BYTES*8-1:0] flow_tuple_t;     // byte 0 sits in bits 7:0

    //////////////////////////////////////////////////
    // record fields and hash keys
    //////////////////////////////////////////////////

    localparam int COUNT_W   = 16;      // per packet byte count
    localparam int FLOW_ID_W = 20;      // id kept next to the count

    // odd multipliers, one per hash
    localparam logic [15:0] ADDR_KEY = 16'h9e37;
    localparam logic [15:0] ID_KEY   = 16'h61c9;

    // one qdr word, 36 bits
    // written raw by the queue, decoded by field on the memory side
    typedef union packed {
        logic [35:0] raw;
        struct packed {
            logic [FLOW_ID_W-1:0] flow_id;      // upper 20 bits
            logic [COUNT_W-1:0]   byte_count;   // lower 16 bits
        } fields;
    } sram_word_u;

endpackage

`default_nettype wire
